/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_game_view
FILELIST  = game_view.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_game_view.sv */
// testbench for game_view_top with APB setup, framebuffer capture and a reference model of each frame
// random limits, seeds, hook geometry and back-pressure come from a fixed-seed LFSR
`timescale 1ns/1ps
`default_nettype none

module tb_game_view;
	import game_pkg::*;
	import pixel_pkg::*;

	localparam int W = 32;
	localparam int H = 24;
	localparam int MAX_FRAME_XFERS = W * H + 16 * 9 + 24; // 3 kinds x 3 items, longest hook
	localparam int NUM_FRAMES = 4;
	localparam int TIMEOUT_CYCLES = 4 * MAX_FRAME_XFERS * NUM_FRAMES;

	logic clk = 1'b0;
	logic resetn;
	logic go;
	logic frame;
	logic game_end;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	pixel_write_t pix_out;
	logic pix_ready = 1'b0;

	logic [31:0] rng = 32'h46e537a8;
	logic ready_pat [0:4095]; // back-pressure pattern filled before use
	int ready_idx = 0;
	logic ready_random;
	logic ready_hold;
	int cycles = 0;
	logic [17:0] log_q[$]; // accepted pixels as {x, y, color}
	logic [17:0] exp_q[$];
	int base;
	logic [7:0] img_exp [0:31][0:31]; // [y][x]
	logic [7:0] img_act [0:31][0:31];
	int cfg_lim [3];
	logic [15:0] cfg_seed;
	int cfg_hx;
	int cfg_hl;
	string cur_test;
	int errors = 0;
	int errs_at_start;
	int passed = 0;
	int failed = 0;

	game_view_top #(.SCREEN_W(W), .SCREEN_H(H)) dut (
		.clk, .resetn, .go, .frame, .game_end, .psel, .penable, .pwrite, .paddr,
		.pwdata, .prdata, .pready, .pslverr, .pix_out, .pix_ready
	);

	initial begin
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (resetn && pix_out.valid && pix_ready)
			log_q.push_back({pix_out.x, pix_out.y, pix_out.color});
	end

	always @(posedge clk) begin
		if (ready_random) begin
			pix_ready <= ready_pat[ready_idx];
			ready_idx <= (ready_idx + 1) % 4096;
		end else begin
			pix_ready <= ready_hold;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, frames did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// 32-bit Galois LFSR with taps 32 22 2 1
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			rng = galois_step(rng);
			v = {v[30:0], rng[0]};
		end
	endtask

	function automatic logic [7:0] item_color(input int k);
		if (k == 0)
			return COLOR_GOLD;
		else if (k == 1)
			return COLOR_STONE;
		return COLOR_DIAMOND;
	endfunction

	function automatic logic [31:0] limits_word();
		return {11'h0, 5'(cfg_lim[2]), 3'h0, 5'(cfg_lim[1]), 3'h0, 5'(cfg_lim[0])};
	endfunction

	function automatic logic [31:0] hook_word();
		return {19'h0, 5'(cfg_hl), 3'h0, 5'(cfg_hx)};
	endfunction

	task automatic compare_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp === act) else begin
			$display("Mismatch in %s (%s): expected %0h, actual %0h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		errs_at_start = errors;
	endtask

	task automatic finish_test();
		if (errors == errs_at_start) begin
			$display("%s: pass", cur_test);
			passed++;
		end else begin
			$display("%s: FAIL with %0d errors", cur_test, errors - errs_at_start);
			failed++;
		end
	endtask

	task automatic apb_write(input logic [11:0] a, input logic [31:0] d, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= a;
		pwdata <= d;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		compare_value("write pready", 32'h1, {31'h0, pready}); // no wait states
		@(posedge clk); // write lands here
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [11:0] a, output logic [31:0] d, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= a;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		d = prdata;
		err = pslverr;
		compare_value("read pready", 32'h1, {31'h0, pready});
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic randomize_config();
		logic [31:0] v;
		for (int k = 0; k < 3; k++) begin
			take_bits(2, v);
			cfg_lim[k] = (v % 3) + 1;
		end
		take_bits(16, v);
		cfg_seed = v[15:0];
		take_bits(5, v);
		cfg_hx = v[4:0];
		take_bits(5, v);
		cfg_hl = (v % 24) + 1; // keep the hook on screen
	endtask

	task automatic program_config();
		logic err;
		apb_write(REG_LIMITS, limits_word(), err);
		compare_value("limits write pslverr", 32'h0, {31'h0, err});
		apb_write(REG_SEED, {16'h0, cfg_seed}, err);
		compare_value("seed write pslverr", 32'h0, {31'h0, err});
		apb_write(REG_HOOK, hook_word(), err);
		compare_value("hook write pslverr", 32'h0, {31'h0, err});
	endtask

	// expected transfer order is background raster, items gold to diamond, hook column
	task automatic build_expected();
		logic [15:0] l;
		logic [4:0] bx;
		logic [4:0] by;
		exp_q.delete();
		for (int y = 0; y < H; y++)
			for (int x = 0; x < W; x++)
				exp_q.push_back({5'(x), 5'(y), COLOR_BG});
		l = cfg_seed;
		for (int k = 0; k < 3; k++) begin
			for (int n = 0; n < cfg_lim[k]; n++) begin
				for (int s = 0; s < 16; s++)
					l = (l >> 1) ^ (l[0] ? 16'hB400 : 16'h0);
				bx = (l[4:0] > 5'(W - 4)) ? 5'(W - 4) : l[4:0];
				by = (l[12:8] > 5'(H - 4)) ? 5'(H - 4) : l[12:8];
				for (int oy = 0; oy < 4; oy++)
					for (int ox = 0; ox < 4; ox++)
						exp_q.push_back({bx + 5'(ox), by + 5'(oy), item_color(k)});
			end
		end
		for (int y = 0; y < cfg_hl; y++)
			exp_q.push_back({5'(cfg_hx), 5'(y), COLOR_HOOK});
	endtask

	task automatic wait_frame_done(input int n);
		logic [31:0] st;
		logic err;
		st = '0;
		while (!(st[3:0] == S_GAME && st[15:8] == 8'(n)))
			apb_read(REG_STATUS, st, err);
	endtask

	task automatic pulse_start(input logic with_frame);
		@(posedge clk);
		go <= 1'b1;
		frame <= with_frame;
		@(posedge clk);
		go <= 1'b0;
		frame <= 1'b0;
	endtask

	task automatic check_frame();
		int n_act;
		int n_exp;
		logic bad;
		logic [17:0] e;
		n_act = log_q.size() - base;
		n_exp = exp_q.size();
		bad = 1'b0;
		compare_value("transfer count", n_exp, n_act);
		for (int i = 0; i < n_exp && i < n_act && !bad; i++) begin
			assert (log_q[base + i] == exp_q[i]) else begin
				$display("Mismatch in %s (transfer %0d): expected %h, actual %h",
					cur_test, i, exp_q[i], log_q[base + i]);
				errors++;
				bad = 1'b1;
			end
		end
		for (int y = 0; y < 32; y++)
			for (int x = 0; x < 32; x++) begin
				img_exp[y][x] = 8'h00;
				img_act[y][x] = 8'h00;
			end
		foreach (exp_q[i]) begin
			e = exp_q[i];
			img_exp[e[12:8]][e[17:13]] = e[7:0];
		end
		for (int i = base; i < log_q.size(); i++) begin
			e = log_q[i];
			img_act[e[12:8]][e[17:13]] = e[7:0];
		end
		bad = 1'b0;
		for (int y = 0; y < H && !bad; y++)
			for (int x = 0; x < W && !bad; x++)
				assert (img_act[y][x] === img_exp[y][x]) else begin
					$display("Mismatch in %s (pixel x=%0d y=%0d): expected %h, actual %h",
						cur_test, x, y, img_exp[y][x], img_act[y][x]);
					errors++;
					bad = 1'b1;
				end
	endtask

	task automatic check_hook();
		for (int y = 0; y < cfg_hl; y++)
			compare_value("hook pixel", 32'(COLOR_HOOK), 32'(img_act[y][cfg_hx]));
	endtask

	// per-kind block counts and gold, stone, diamond order in the item section
	task automatic check_items();
		int cnt [3];
		int rank;
		int last_rank;
		logic [7:0] c;
		cnt = '{0, 0, 0};
		last_rank = 0;
		for (int i = base + W * H; i < log_q.size() - cfg_hl; i++) begin
			c = log_q[i][7:0];
			rank = (c == COLOR_GOLD) ? 0 : (c == COLOR_STONE) ? 1 : (c == COLOR_DIAMOND) ? 2 : 3;
			assert (rank < 3 && rank >= last_rank) else begin
				$display("%s: item pixel %0d has color %h out of kind order", cur_test, i, c);
				errors++;
			end
			if (rank < 3)
				cnt[rank]++;
			last_rank = rank;
		end
		for (int k = 0; k < 3; k++)
			compare_value("item pixels of one kind", 16 * cfg_lim[k], cnt[k]);
	endtask

	initial begin
		logic [31:0] v;
		logic err;
		resetn = 1'b0;
		go = 1'b0;
		frame = 1'b0;
		game_end = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		ready_hold = 1'b0; // first background stalls during the register test
		ready_random = 1'b0;
		repeat (2) @(posedge clk);
		resetn <= 1'b1;

		start_test("apb_rw");
		apb_read(REG_LIMITS, v, err);
		compare_value("limits reset", 32'h00010202, v);
		apb_read(REG_SEED, v, err);
		compare_value("seed reset", 32'h0000ACE1, v);
		apb_read(REG_HOOK, v, err);
		compare_value("hook reset", 32'h00000810, v);
		randomize_config();
		program_config();
		apb_read(REG_LIMITS, v, err);
		compare_value("limits readback", limits_word(), v);
		apb_read(REG_SEED, v, err);
		compare_value("seed readback", {16'h0, cfg_seed}, v);
		apb_read(REG_HOOK, v, err);
		compare_value("hook readback", hook_word(), v);
		compare_value("mapped read pslverr", 32'h0, {31'h0, err});
		apb_write(12'h010, 32'h1234, err);
		compare_value("unmapped write pslverr", 32'h1, {31'h0, err});
		apb_read(12'h014, v, err);
		compare_value("unmapped read pslverr", 32'h1, {31'h0, err});
		cfg_lim = '{2, 2, 1};
		cfg_seed = 16'hACE1;
		cfg_hx = 16;
		cfg_hl = 8;
		program_config();
		finish_test();

		start_test("first_frame");
		build_expected();
		base = 0;
		ready_hold <= 1'b1;
		wait_frame_done(1);
		check_frame();
		finish_test();

		start_test("hook_column");
		check_hook();
		finish_test();

		start_test("random_items");
		randomize_config();
		program_config();
		build_expected();
		base = log_q.size();
		pulse_start(1'b1);
		wait_frame_done(2);
		check_frame();
		check_items();
		check_hook();
		finish_test();

		start_test("backpressure");
		for (int i = 0; i < 4096; i++) begin
			take_bits(2, v);
			ready_pat[i] = |v[1:0];
		end
		randomize_config();
		program_config();
		build_expected();
		base = log_q.size();
		ready_random <= 1'b1;
		pulse_start(1'b1);
		wait_frame_done(3);
		ready_random <= 1'b0;
		check_frame();
		check_items();
		finish_test();

		start_test("game_end");
		@(posedge clk);
		game_end <= 1'b1;
		@(posedge clk);
		game_end <= 1'b0;
		apb_read(REG_STATUS, v, err);
		compare_value("status state", 32'(S_GAME_DONE), {28'h0, v[3:0]});
		compare_value("frames drawn", 32'd3, {24'h0, v[15:8]});
		randomize_config();
		program_config();
		build_expected();
		base = log_q.size();
		pulse_start(1'b0); // go alone restarts after game end
		wait_frame_done(4);
		check_frame();
		check_hook();
		finish_test();

		$display("tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* game_view.f */
source/game_pkg.sv
source/pixel_pkg.sv
source/view_regs.sv
source/view_fsm.sv
source/scene_drawer.sv
source/item_drawer.sv
source/pixel_merge.sv
source/game_view_top.sv
dv/tb_game_view.sv

/* source/game_pkg.sv */
// game-level types shared by the register block, sequencer and item drawer
// also holds the APB register map of the view controller
`default_nettype none

package game_pkg;

	// sequencer states, one frame walks START..GAME
	typedef enum logic [3:0] {
		S_START,
		S_BACKGROUND,
		S_BG_WAIT,
		S_ITEM,
		S_ITEM_DONE,
		S_HOOK,
		S_HOOK_WAIT,
		S_GAME,
		S_GAME_DONE
	} view_state_t;

	typedef enum logic [1:0] {
		ITEM_GOLD,
		ITEM_STONE,
		ITEM_DIAMOND
	} item_kind_t;

	// byte offsets on the APB side
	localparam logic [11:0] REG_LIMITS = 12'h000;
	localparam logic [11:0] REG_SEED   = 12'h004;
	localparam logic [11:0] REG_HOOK   = 12'h008;
	localparam logic [11:0] REG_STATUS = 12'h00C; // read only

	typedef struct packed {
		logic [4:0] max_gold;
		logic [4:0] max_stone;
		logic [4:0] max_diamond;
	} limits_t;

	typedef struct packed {
		logic [4:0] hook_x;
		logic [4:0] hook_len;
	} hook_cfg_t;

endpackage

`default_nettype wire

/* source/game_view_top.sv */
// top of the frame-drawing block: APB registers, sequencer, two drawers and the pixel merge
// drives one framebuffer write port with back-pressure
`timescale 1ns/1ps
`default_nettype none

module game_view_top #(
	parameter int SCREEN_W = 32,
	parameter int SCREEN_H = 24
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    go,
	input  logic                    frame,
	input  logic                    game_end,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [11:0]             paddr,
	input  logic [31:0]             pwdata,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	output pixel_pkg::pixel_write_t pix_out,
	input  logic                    pix_ready
);
	import game_pkg::*;
	import pixel_pkg::*;

	limits_t      limits;
	hook_cfg_t    hook_cfg;
	logic [15:0]  seed;
	view_state_t  state;
	logic [7:0]   frames_drawn;
	logic         bg_start;
	logic         hook_start;
	logic         item_start;
	logic         item_first;
	item_kind_t   item_kind;
	logic         scene_done;
	logic         item_done;
	pixel_write_t scene_pix;
	pixel_write_t item_pix;
	logic         scene_ready;
	logic         item_ready;

	view_regs u_regs (
		.clk, .resetn, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .state, .frames_drawn,
		.limits, .seed, .hook_cfg
	);

	view_fsm u_fsm (
		.clk, .resetn, .go, .frame, .game_end, .limits,
		.bg_start, .hook_start, .item_start, .item_first, .item_kind,
		.scene_done, .item_done, .state, .frames_drawn
	);

	scene_drawer #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_scene (
		.clk, .resetn, .bg_start, .hook_start, .hook_cfg,
		.pix(scene_pix), .ready(scene_ready), .done(scene_done)
	);

	item_drawer #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_item (
		.clk, .resetn, .item_start, .item_first, .item_kind, .seed,
		.pix(item_pix), .ready(item_ready), .done(item_done)
	);

	pixel_merge u_merge (
		.clk, .resetn, .scene_pix, .item_pix, .scene_ready, .item_ready,
		.pix_out, .pix_ready
	);

endmodule

`default_nettype wire

/* source/item_drawer.sv */
// places one 4x4 item per request using a Galois LFSR and rasters it in the item's color
// the LFSR reloads from seed on the first item of each frame
`timescale 1ns/1ps
`default_nettype none

module item_drawer #(
	parameter int SCREEN_W = 32,
	parameter int SCREEN_H = 24
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    item_start,
	input  logic                    item_first,
	input  game_pkg::item_kind_t    item_kind,
	input  logic [15:0]             seed,
	output pixel_pkg::pixel_write_t pix,
	input  logic                    ready,
	output logic                    done
);
	import game_pkg::*;
	import pixel_pkg::*;

	logic [15:0] lfsr;
	logic [15:0] lfsr_nxt;
	logic        busy;
	logic        fire;
	logic        last;
	coord_t      x_raw;
	coord_t      y_raw;
	coord_t      base_x;
	coord_t      base_y;
	logic [1:0]  off_x;
	logic [1:0]  off_y;
	color_t      color_q;
	color_t      kind_color;

	// 16 steps of x^16 style Galois LFSR, mask 0xB400
	function automatic logic [15:0] lfsr_step16(input logic [15:0] v);
		logic [15:0] r;
		r = v;
		for (int i = 0; i < 16; i++)
			r = {1'b0, r[15:1]} ^ (r[0] ? 16'hB400 : 16'h0000);
		return r;
	endfunction

	assign lfsr_nxt = lfsr_step16(item_first ? seed : lfsr);
	assign x_raw    = lfsr_nxt[4:0];
	assign y_raw    = lfsr_nxt[12:8];
	assign fire     = busy && ready;
	assign last     = (off_x == 2'd3) && (off_y == 2'd3);

	always_comb begin
		case (item_kind)
			ITEM_STONE:   kind_color = COLOR_STONE;
			ITEM_DIAMOND: kind_color = COLOR_DIAMOND;
			default:      kind_color = COLOR_GOLD;
		endcase
	end

	assign pix.valid = busy;
	assign pix.x     = base_x + coord_t'(off_x);
	assign pix.y     = base_y + coord_t'(off_y);
	assign pix.color = color_q;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= fire && last;
			if (!busy && item_start)
				busy <= 1'b1;
			else if (fire && last)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && item_start) begin
			lfsr    <= lfsr_nxt;
			// keep the whole block on screen
			base_x  <= (int'(x_raw) > SCREEN_W - 4) ? coord_t'(SCREEN_W - 4) : x_raw;
			base_y  <= (int'(y_raw) > SCREEN_H - 4) ? coord_t'(SCREEN_H - 4) : y_raw;
			color_q <= kind_color;
			off_x   <= 2'd0;
			off_y   <= 2'd0;
		end else if (fire) begin
			off_x <= off_x + 2'd1; // wraps at 3
			if (off_x == 2'd3)
				off_y <= off_y + 2'd1;
		end
	end

endmodule

`default_nettype wire

/* source/pixel_merge.sv */
// merges the scene and item pixel streams onto the single framebuffer write port
`timescale 1ns/1ps
`default_nettype none

module pixel_merge (
	input  logic                    clk,
	input  logic                    resetn,
	input  pixel_pkg::pixel_write_t scene_pix,
	input  pixel_pkg::pixel_write_t item_pix,
	output logic                    scene_ready,
	output logic                    item_ready,
	output pixel_pkg::pixel_write_t pix_out,
	input  logic                    pix_ready
);
	// sequencer runs one drawer at a time, so a plain select is enough
	assign pix_out     = scene_pix.valid ? scene_pix : item_pix;
	assign scene_ready = pix_ready && scene_pix.valid;
	assign item_ready  = pix_ready && !scene_pix.valid; // item side sees ready only when scene idle

	assert property (@(posedge clk) disable iff (!resetn)
		!(scene_pix.valid && item_pix.valid));

endmodule

`default_nettype wire

/* source/pixel_pkg.sv */
// pixel types and the fixed palette used by both drawing engines
`default_nettype none

package pixel_pkg;

	typedef logic [7:0] color_t;
	typedef logic [4:0] coord_t;

	localparam color_t COLOR_BG      = 8'h11;
	localparam color_t COLOR_GOLD    = 8'hF0;
	localparam color_t COLOR_STONE   = 8'h92;
	localparam color_t COLOR_DIAMOND = 8'h1F;
	localparam color_t COLOR_HOOK    = 8'hFF;

	// one framebuffer write, held stable while valid and not accepted
	typedef struct packed {
		logic   valid;
		coord_t x;
		coord_t y;
		color_t color;
	} pixel_write_t;

endpackage

`default_nettype wire

/* source/scene_drawer.sv */
// raster engine for the full-screen background fill and the vertical hook line
// one start runs one pass, done pulses a cycle after the last accepted pixel
`timescale 1ns/1ps
`default_nettype none

module scene_drawer #(
	parameter int SCREEN_W = 32,
	parameter int SCREEN_H = 24
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    bg_start,
	input  logic                    hook_start,
	input  game_pkg::hook_cfg_t     hook_cfg,
	output pixel_pkg::pixel_write_t pix,
	input  logic                    ready,
	output logic                    done
);
	import pixel_pkg::*;

	logic   busy;
	logic   hook_mode; // 0 background, 1 hook column
	logic   fire;
	logic   last;
	logic   hook_empty;
	coord_t x;
	coord_t y;
	coord_t hook_len_q;

	assign fire       = busy && ready;
	assign hook_empty = hook_cfg.hook_len == 5'd0;
	assign last = hook_mode ? (y == hook_len_q - 5'd1) :
		((x == coord_t'(SCREEN_W - 1)) && (y == coord_t'(SCREEN_H - 1)));

	assign pix.valid = busy;
	assign pix.x     = x;
	assign pix.y     = y;
	assign pix.color = hook_mode ? COLOR_HOOK : COLOR_BG;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy      <= 1'b0;
			hook_mode <= 1'b0;
			done      <= 1'b0;
		end else begin
			// zero-length hook finishes without any pixel
			done <= (fire && last) || (!busy && !bg_start && hook_start && hook_empty);
			if (!busy) begin
				if (bg_start) begin
					busy      <= 1'b1;
					hook_mode <= 1'b0;
				end else if (hook_start && !hook_empty) begin
					busy      <= 1'b1;
					hook_mode <= 1'b1;
				end
			end else if (fire && last) begin
				busy <= 1'b0;
			end
		end
	end

	// raster counters, step only on accepted pixels
	always_ff @(posedge clk) begin
		if (!busy) begin
			x          <= bg_start ? coord_t'(0) : hook_cfg.hook_x;
			y          <= coord_t'(0);
			hook_len_q <= hook_cfg.hook_len;
		end else if (fire && !last) begin
			if (hook_mode) begin
				y <= y + 5'd1;
			end else if (x == coord_t'(SCREEN_W - 1)) begin
				x <= coord_t'(0);
				y <= y + 5'd1;
			end else begin
				x <= x + 5'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/view_fsm.sv */
// frame sequencer: background, then gold/stone/diamond items up to their limits, then hook
// waits in GAME for the next frame tick, or in GAME_DONE after the game has ended
`timescale 1ns/1ps
`default_nettype none

module view_fsm (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  go,
	input  logic                  frame,
	input  logic                  game_end,
	input  game_pkg::limits_t     limits,
	output logic                  bg_start,
	output logic                  hook_start,
	output logic                  item_start,
	output logic                  item_first,
	output game_pkg::item_kind_t  item_kind,
	input  logic                  scene_done,
	input  logic                  item_done,
	output game_pkg::view_state_t state,
	output logic [7:0]            frames_drawn
);
	import game_pkg::*;

	view_state_t next_state;
	item_kind_t  pick_kind;
	logic [4:0]  gold_cnt;
	logic [4:0]  stone_cnt;
	logic [4:0]  diamond_cnt;
	logic        gold_full;
	logic        stone_full;
	logic        diamond_full;
	logic        new_frame;
	logic        scene_busy; // start issued, done not yet seen
	logic        item_busy;

	assign gold_full    = gold_cnt >= limits.max_gold;
	assign stone_full   = stone_cnt >= limits.max_stone;
	assign diamond_full = diamond_cnt >= limits.max_diamond;
	assign new_frame    = (next_state == S_BACKGROUND) && (state != S_BACKGROUND);

	// gold first, then stone, then diamond
	always_comb begin
		pick_kind = ITEM_GOLD;
		if (gold_full && stone_full)
			pick_kind = ITEM_DIAMOND;
		else if (gold_full)
			pick_kind = ITEM_STONE;
	end

	always_comb begin
		next_state = state;
		case (state)
			S_START:      next_state = S_BACKGROUND;
			S_BACKGROUND: next_state = scene_done ? S_BG_WAIT : S_BACKGROUND;
			S_BG_WAIT: begin
				if (gold_full && stone_full && diamond_full)
					next_state = S_HOOK;
				else
					next_state = S_ITEM;
			end
			S_ITEM:       next_state = item_done ? S_ITEM_DONE : S_ITEM;
			S_ITEM_DONE:  next_state = S_BG_WAIT;
			S_HOOK:       next_state = S_HOOK_WAIT;
			S_HOOK_WAIT:  next_state = scene_done ? S_GAME : S_HOOK_WAIT;
			S_GAME: begin
				if (game_end)
					next_state = S_GAME_DONE;
				else if (frame && go)
					next_state = S_BACKGROUND;
			end
			S_GAME_DONE:  next_state = go ? S_BACKGROUND : S_GAME_DONE;
			default:      next_state = S_START;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state        <= S_START;
			bg_start     <= 1'b0;
			hook_start   <= 1'b0;
			item_start   <= 1'b0;
			item_first   <= 1'b0;
			item_kind    <= ITEM_GOLD;
			gold_cnt     <= 5'd0;
			stone_cnt    <= 5'd0;
			diamond_cnt  <= 5'd0;
			frames_drawn <= 8'd0;
		end else begin
			state      <= next_state;
			// pulses land on the first cycle of their state
			bg_start   <= new_frame;
			hook_start <= (next_state == S_HOOK) && (state != S_HOOK);
			item_start <= (next_state == S_ITEM) && (state != S_ITEM);
			if (state == S_BG_WAIT && next_state == S_ITEM) begin
				item_kind  <= pick_kind;
				item_first <= (gold_cnt == 5'd0) && (stone_cnt == 5'd0) &&
					(diamond_cnt == 5'd0);
			end
			if (new_frame) begin
				gold_cnt    <= 5'd0;
				stone_cnt   <= 5'd0;
				diamond_cnt <= 5'd0;
			end else if (state == S_ITEM_DONE) begin
				case (item_kind)
					ITEM_GOLD:    gold_cnt    <= gold_cnt + 5'd1;
					ITEM_STONE:   stone_cnt   <= stone_cnt + 5'd1;
					ITEM_DIAMOND: diamond_cnt <= diamond_cnt + 5'd1;
					default:      ;
				endcase
			end
			if (state == S_HOOK_WAIT && scene_done)
				frames_drawn <= frames_drawn + 8'd1; // frame complete
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			scene_busy <= 1'b0;
			item_busy  <= 1'b0;
		end else begin
			scene_busy <= (scene_busy && !scene_done) || bg_start || hook_start;
			item_busy  <= (item_busy && !item_done) || item_start;
		end
	end

	// a drawer is never restarted before it reported done, and never overlaps the other
	assert property (@(posedge clk) disable iff (!resetn)
		(bg_start || hook_start) |-> !(scene_busy || item_busy));
	assert property (@(posedge clk) disable iff (!resetn)
		item_start |-> !(item_busy || scene_busy));

endmodule

`default_nettype wire

/* source/view_regs.sv */
// APB register block for the view controller
// holds item limits, placement seed and hook geometry, reports sequencer status
`timescale 1ns/1ps
`default_nettype none

module view_regs (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [11:0]           paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  game_pkg::view_state_t state,
	input  logic [7:0]            frames_drawn,
	output game_pkg::limits_t     limits,
	output logic [15:0]           seed,
	output game_pkg::hook_cfg_t   hook_cfg
);
	import game_pkg::*;

	logic access;
	logic mapped;

	assign access = psel && penable;
	assign mapped = (paddr == REG_LIMITS) || (paddr == REG_SEED) ||
		(paddr == REG_HOOK) || (paddr == REG_STATUS);

	assign pready  = 1'b1; // no wait states
	assign pslverr = access && !mapped;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			limits.max_gold    <= 5'd2;
			limits.max_stone   <= 5'd2;
			limits.max_diamond <= 5'd1;
			seed               <= 16'hACE1;
			hook_cfg.hook_x    <= 5'd16;
			hook_cfg.hook_len  <= 5'd8;
		end else if (access && pwrite) begin
			case (paddr)
				REG_LIMITS: begin
					limits.max_gold    <= pwdata[4:0];
					limits.max_stone   <= pwdata[12:8];
					limits.max_diamond <= pwdata[20:16];
				end
				REG_SEED: seed <= pwdata[15:0];
				REG_HOOK: begin
					hook_cfg.hook_x   <= pwdata[4:0];
					hook_cfg.hook_len <= pwdata[12:8];
				end
				default: ; // status is read only
			endcase
		end
	end

	always_comb begin
		prdata = 32'h0;
		if (psel && !pwrite) begin
			case (paddr)
				REG_LIMITS: prdata = {11'h0, limits.max_diamond, 3'h0, limits.max_stone,
					3'h0, limits.max_gold};
				REG_SEED:   prdata = {16'h0, seed};
				REG_HOOK:   prdata = {19'h0, hook_cfg.hook_len, 3'h0, hook_cfg.hook_x};
				REG_STATUS: prdata = {16'h0, frames_drawn, 4'h0, state};
				default:    prdata = 32'h0;
			endcase
		end
	end

	// master must hold psel through the access phase
	assert property (@(posedge clk) disable iff (!resetn) penable |-> psel);

endmodule

`default_nettype wire
